//--- src/ahbApb_config.svh
//##############################
// Bridge widths and address map. The APB window is three equal regions
// from AHB_APB_BASE upward, one region per peripheral.
//##############################
`ifndef AHB_APB_CONFIG_SVH
`define AHB_APB_CONFIG_SVH

// Data bus width. Only 32-bit transfers are supported.
`define AHB_APB_DATA_W 32

// Address bus width.
`define AHB_APB_ADDR_W 32

// Number of APB peripherals, also the Pselx width.
`define AHB_APB_NSLV 3

// First address of the bridge window.
`define AHB_APB_BASE 32'h8000_0000

// Size of each peripheral region.
`define AHB_APB_REGION 32'h0400_0000

`endif

//--- src/ahbApbPkg.sv
//##############################
// Shared types of the bridge. The struct field widths come from
// the config header.
//##############################
`include "ahbApb_config.svh"

package ahbApbPkg;

	// AHB transfer type, encoded as on the bus.
	typedef enum logic [1:0]
	{
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htransE;

	// APB sequencer states.
	typedef enum logic [2:0]
	{
		stIdle     = 3'b000,
		stWwait    = 3'b001,
		stRead     = 3'b010,
		stWrite    = 3'b011,
		stWriteP   = 3'b100,
		stRenable  = 3'b101,
		stWenable  = 3'b110,
		stWenableP = 3'b111
	} fsmStateE;

	// One AHB address phase.
	typedef struct packed
	{
		logic [`AHB_APB_ADDR_W-1:0] Haddr;
		htransE                     Htrans;
		logic                       Hwrite;
	} ahbReqS;

	// APB master outputs.
	typedef struct packed
	{
		logic [`AHB_APB_ADDR_W-1:0] Paddr;
		logic [`AHB_APB_DATA_W-1:0] Pwdata;
		logic                       Pwrite;
		logic [`AHB_APB_NSLV-1:0]   Pselx;
		logic                       Penable;
	} apbReqS;

endpackage

//--- src/ahbSlaveInterface.sv
//##############################
// AHB-Lite slave side. Hsize, Hburst and Hresp are not handled.
// Addresses outside the three regions are not valid.
//##############################
`timescale 1ns/1ps
`include "ahbApb_config.svh"

module ahbSlaveInterface
(
	input  logic                         Hclk,
	input  logic                         Hresetn,
	input  ahbApbPkg::ahbReqS            ahbReq,
	input  logic [`AHB_APB_DATA_W-1:0]   Hwdata,
	input  logic                         Hreadyin,
	input  logic [`AHB_APB_DATA_W-1:0]   Prdata,
	output logic                         valid,
	output logic [`AHB_APB_NSLV-1:0]     tempselx,
	output logic [`AHB_APB_ADDR_W-1:0]   Haddr1,
	output logic [`AHB_APB_ADDR_W-1:0]   Haddr2,
	output logic [`AHB_APB_DATA_W-1:0]   Hwdata1,
	output logic [`AHB_APB_DATA_W-1:0]   Hwdata2,
	output logic                         Hwritereg,
	output logic [`AHB_APB_DATA_W-1:0]   Hrdata
);

	logic [`AHB_APB_ADDR_W-1:0] offset;
	logic                       inWindow;
	logic                       activeTrans;

	// Two-deep address and data shift, free running.
	always_ff @(posedge Hclk)
	begin
		Haddr1  <= ahbReq.Haddr;
		Haddr2  <= Haddr1;
		Hwdata1 <= Hwdata;
		Hwdata2 <= Hwdata1;
	end

	// Write flag of the last accepted address phase.
	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			Hwritereg <= 1'b0;
		end
		else if (Hreadyin)
		begin
			Hwritereg <= ahbReq.Hwrite;
		end
	end

	assign offset = ahbReq.Haddr - `AHB_APB_BASE;

	assign inWindow = (ahbReq.Haddr >= `AHB_APB_BASE) &&
		(offset < `AHB_APB_NSLV * `AHB_APB_REGION);

	assign activeTrans = (ahbReq.Htrans == ahbApbPkg::NONSEQ) ||
		(ahbReq.Htrans == ahbApbPkg::SEQ);

	assign valid = Hreadyin && activeTrans && inWindow;

	// One-hot select from the region index.
	always_comb
	begin
		tempselx = '0;
		for (int i = 0; i < `AHB_APB_NSLV; i++)
		begin
			if (inWindow && (offset / `AHB_APB_REGION) == i)
			begin
				tempselx[i] = 1'b1;
			end
		end
	end

	assign Hrdata = Prdata; // Sampled by the master when Hreadyout is high.

endmodule

//--- src/apbFsmController.sv
//##############################
// APB setup and enable sequencer. APB slaves have no wait states,
// so there is no Pready. Hreadyout is low from setup to enable.
//##############################
`timescale 1ns/1ps
`include "ahbApb_config.svh"

module apbFsmController
(
	input  logic                         Hclk,
	input  logic                         Hresetn,
	input  logic                         valid,
	input  ahbApbPkg::ahbReqS            ahbReq,
	input  logic [`AHB_APB_DATA_W-1:0]   Hwdata,
	input  logic [`AHB_APB_ADDR_W-1:0]   Haddr1,
	input  logic [`AHB_APB_ADDR_W-1:0]   Haddr2,
	input  logic [`AHB_APB_DATA_W-1:0]   Hwdata1,
	input  logic [`AHB_APB_DATA_W-1:0]   Hwdata2,
	input  logic                         Hwritereg,
	input  logic [`AHB_APB_NSLV-1:0]     tempselx,
	output ahbApbPkg::apbReqS            apbReq,
	output logic                         Hreadyout
);

	ahbApbPkg::fsmStateE state;
	ahbApbPkg::fsmStateE nextState;

	ahbApbPkg::apbReqS          apbNext;
	logic                       hreadyNext;
	logic [`AHB_APB_NSLV-1:0]   sel1;
	logic [`AHB_APB_NSLV-1:0]   sel2;

	// Select follows the address pipeline.
	always_ff @(posedge Hclk)
	begin
		sel1 <= tempselx;
		sel2 <= sel1;
	end

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			state <= ahbApbPkg::stIdle;
		end
		else
		begin
			state <= nextState;
		end
	end

	always_comb
	begin
		nextState = state;
		case (state)
			ahbApbPkg::stIdle,
			ahbApbPkg::stRenable,
			ahbApbPkg::stWenable:
			begin
				if (!valid)
					nextState = ahbApbPkg::stIdle;
				else if (ahbReq.Hwrite)
					nextState = ahbApbPkg::stWwait; // Data comes next cycle.
				else
					nextState = ahbApbPkg::stRead;
			end
			ahbApbPkg::stWwait:
			begin
				if (valid)
					nextState = ahbApbPkg::stWriteP;
				else
					nextState = ahbApbPkg::stWrite;
			end
			ahbApbPkg::stRead:
			begin
				nextState = ahbApbPkg::stRenable;
			end
			ahbApbPkg::stWrite:
			begin
				nextState = ahbApbPkg::stWenable;
			end
			ahbApbPkg::stWriteP:
			begin
				nextState = ahbApbPkg::stWenableP;
			end
			ahbApbPkg::stWenableP:
			begin
				if (Hwritereg)
					nextState = ahbApbPkg::stWrite;
				else
					nextState = ahbApbPkg::stRead;
			end
			default:
			begin
				nextState = ahbApbPkg::stIdle;
			end
		endcase
	end

	// Next value of the registered outputs, old value kept by default.
	always_comb
	begin
		apbNext    = apbReq;
		hreadyNext = Hreadyout;
		case (state)
			ahbApbPkg::stIdle,
			ahbApbPkg::stRenable,
			ahbApbPkg::stWenable:
			begin
				apbNext.Penable = 1'b0;
				if (valid && !ahbReq.Hwrite)
				begin
					apbNext.Paddr  = ahbReq.Haddr; // Read setup.
					apbNext.Pwrite = 1'b0;
					apbNext.Pselx  = tempselx;
					hreadyNext     = 1'b0;
				end
				else
				begin
					apbNext.Pselx = '0;
					hreadyNext    = 1'b1;
				end
			end
			ahbApbPkg::stWwait:
			begin
				apbNext.Paddr   = Haddr1;
				apbNext.Pwdata  = Hwdata;
				apbNext.Pwrite  = 1'b1;
				apbNext.Pselx   = sel1;
				apbNext.Penable = 1'b0;
				hreadyNext      = 1'b0;
			end
			ahbApbPkg::stRead,
			ahbApbPkg::stWrite:
			begin
				apbNext.Penable = 1'b1;
				hreadyNext      = 1'b1; // Transfer ends with the enable cycle.
			end
			ahbApbPkg::stWriteP:
			begin
				apbNext.Penable = 1'b1;
				hreadyNext      = 1'b0; // Pipelined transfer still pending.
			end
			ahbApbPkg::stWenableP:
			begin
				apbNext.Paddr   = Haddr2;
				apbNext.Pwdata  = Hwdata1; // Data lags its address by one stage.
				apbNext.Pwrite  = Hwritereg;
				apbNext.Pselx   = sel2;
				apbNext.Penable = 1'b0;
				hreadyNext      = 1'b0;
			end
			default:
			begin
				apbNext.Pselx   = '0;
				apbNext.Penable = 1'b0;
				hreadyNext      = 1'b1;
			end
		endcase
	end

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			apbReq.Pwrite  <= 1'b0;
			apbReq.Pselx   <= '0;
			apbReq.Penable <= 1'b0;
			Hreadyout      <= 1'b0;
		end
		else
		begin
			apbReq.Pwrite  <= apbNext.Pwrite;
			apbReq.Pselx   <= apbNext.Pselx;
			apbReq.Penable <= apbNext.Penable;
			Hreadyout      <= hreadyNext;
		end
	end

	// Address and write data carry no reset.
	always_ff @(posedge Hclk)
	begin
		apbReq.Paddr  <= apbNext.Paddr;
		apbReq.Pwdata <= apbNext.Pwdata;
	end

endmodule

//--- src/ahbApbBridge.sv
//##############################
// AHB-Lite to APB bridge top. Hreadyin is expected to be
// tied to Hreadyout outside.
//##############################
`timescale 1ns/1ps
`include "ahbApb_config.svh"

module ahbApbBridge
(
	input  logic                         Hclk,
	input  logic                         Hresetn,
	input  ahbApbPkg::ahbReqS            ahbReq,
	input  logic [`AHB_APB_DATA_W-1:0]   Hwdata,
	input  logic                         Hreadyin,
	output logic                         Hreadyout,
	output logic [`AHB_APB_DATA_W-1:0]   Hrdata,
	output ahbApbPkg::apbReqS            apbReq,
	input  logic [`AHB_APB_DATA_W-1:0]   Prdata
);

	logic                       valid;
	logic [`AHB_APB_NSLV-1:0]   tempselx;
	logic [`AHB_APB_ADDR_W-1:0] Haddr1;
	logic [`AHB_APB_ADDR_W-1:0] Haddr2;
	logic [`AHB_APB_DATA_W-1:0] Hwdata1;
	logic [`AHB_APB_DATA_W-1:0] Hwdata2;
	logic                       Hwritereg;

	ahbSlaveInterface slaveIf
	(
		.Hclk      (Hclk),
		.Hresetn   (Hresetn),
		.ahbReq    (ahbReq),
		.Hwdata    (Hwdata),
		.Hreadyin  (Hreadyin),
		.Prdata    (Prdata),
		.valid     (valid),
		.tempselx  (tempselx),
		.Haddr1    (Haddr1),
		.Haddr2    (Haddr2),
		.Hwdata1   (Hwdata1),
		.Hwdata2   (Hwdata2),
		.Hwritereg (Hwritereg),
		.Hrdata    (Hrdata)
	);

	apbFsmController fsm
	(
		.Hclk      (Hclk),
		.Hresetn   (Hresetn),
		.valid     (valid),
		.ahbReq    (ahbReq),
		.Hwdata    (Hwdata),
		.Haddr1    (Haddr1),
		.Haddr2    (Haddr2),
		.Hwdata1   (Hwdata1),
		.Hwdata2   (Hwdata2),
		.Hwritereg (Hwritereg),
		.tempselx  (tempselx),
		.apbReq    (apbReq),
		.Hreadyout (Hreadyout)
	);

endmodule

//--- verification/ahbApbBridge_asserts.sv
//##############################
// APB and AHB protocol checks, bound into the bridge top.
// All checks are off while Hresetn is low.
//##############################
`timescale 1ns/1ps

module ahbApbBridgeAsserts
(
	input logic              Hclk,
	input logic              Hresetn,
	input ahbApbPkg::apbReqS apbReq,
	input logic              Hreadyout
);

	int   failCount = 0;
	logic setupCycle;

	assign setupCycle = (apbReq.Pselx != '0) && !apbReq.Penable;

	enableAfterSetup: assert property (@(posedge Hclk) disable iff (!Hresetn)
		apbReq.Penable |-> $past(setupCycle))
	else
	begin
		$error("Penable high without a setup cycle before it");
		failCount++;
	end

	// Write data only matters on writes.
	stableInTransfer: assert property (@(posedge Hclk) disable iff (!Hresetn)
		setupCycle |=> $stable(apbReq.Paddr) && $stable(apbReq.Pwrite) &&
			(!apbReq.Pwrite || $stable(apbReq.Pwdata)))
	else
	begin
		$error("APB address or control changed between setup and enable");
		failCount++;
	end

	selectOneHot: assert property (@(posedge Hclk) disable iff (!Hresetn)
		$onehot0(apbReq.Pselx))
	else
	begin
		$error("Pselx has more than one bit set");
		failCount++;
	end

	stallInSetup: assert property (@(posedge Hclk) disable iff (!Hresetn)
		setupCycle |-> !Hreadyout)
	else
	begin
		$error("Hreadyout high during an APB setup cycle");
		failCount++;
	end

endmodule

bind ahbApbBridge ahbApbBridgeAsserts protocolChecks
(
	.Hclk      (Hclk),
	.Hresetn   (Hresetn),
	.apbReq    (apbReq),
	.Hreadyout (Hreadyout)
);

//--- verification/ahbApbBridgeTb.sv
//##############################
// Random AHB master against the bridge. Hreadyin is tied to
// Hreadyout. Each APB peripheral model holds 16 words.
//##############################
`timescale 1ns/1ps
`include "ahbApb_config.svh"

module ahbApbBridgeTb;

	localparam int numTransfers   = 200;
	localparam int resetCycles    = 8;
	localparam int clkPeriod      = 4;
	localparam int memWords       = 16;
	localparam int watchdogCycles = numTransfers * 6 + resetCycles;
	localparam ahbApbPkg::ahbReqS idleReq = '{Haddr: '0, Htrans: ahbApbPkg::IDLE, Hwrite: 1'b0};

	logic                       Hclk = 1'b0;
	logic                       Hresetn;
	ahbApbPkg::ahbReqS          ahbReq;
	logic [`AHB_APB_DATA_W-1:0] Hwdata;
	logic                       Hreadyin;
	logic                       Hreadyout;
	logic [`AHB_APB_DATA_W-1:0] Hrdata;
	ahbApbPkg::apbReqS          apbReq;
	logic [`AHB_APB_DATA_W-1:0] Prdata;

	integer                     seed = 32'h41ac;
	ahbApbPkg::apbReqS          refQ[$]; // Expected APB transfers, AHB order.
	logic [`AHB_APB_DATA_W-1:0] refMem [`AHB_APB_NSLV][memWords];
	logic [`AHB_APB_DATA_W-1:0] periphMem [`AHB_APB_NSLV][memWords];
	int                         burstLeft = 0;
	bit                         burstOutside;
	int                         burstRegion;
	int                         burstWord;
	ahbApbPkg::apbReqS          enableExp;
	bit                         enablePending = 1'b0;

	ahbApbBridge dut
	(
		.Hclk      (Hclk),
		.Hresetn   (Hresetn),
		.ahbReq    (ahbReq),
		.Hwdata    (Hwdata),
		.Hreadyin  (Hreadyin),
		.Hreadyout (Hreadyout),
		.Hrdata    (Hrdata),
		.apbReq    (apbReq),
		.Prdata    (Prdata)
	);

	assign Hreadyin = Hreadyout; // Single slave on the bus.

	always #(clkPeriod / 2) Hclk = ~Hclk;

	function automatic int randBelow(input int n);
		int r;
		r = $random(seed);
		return (r & 32'h7fff_ffff) % n;
	endfunction

	function automatic logic [`AHB_APB_ADDR_W-1:0] makeAddr(input bit outside,
		input int region, input int word);
		if (outside)
			return (region == 0) ? `AHB_APB_BASE + `AHB_APB_NSLV * `AHB_APB_REGION + word * 4 :
				32'h0000_1000 + word * 4;
		return `AHB_APB_BASE + region * `AHB_APB_REGION + word * 4;
	endfunction

	function automatic int selIndex(input logic [`AHB_APB_NSLV-1:0] sel);
		int idx;
		idx = 0;
		for (int i = 0; i < `AHB_APB_NSLV; i++)
			if (sel[i])
				idx = i;
		return idx;
	endfunction

	task automatic reportFailure();
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic checkApb(input ahbApbPkg::apbReqS got, input ahbApbPkg::apbReqS expReq);
		if (got.Paddr !== expReq.Paddr)
		begin
			$display("FAIL Paddr got %h expected %h", got.Paddr, expReq.Paddr);
			reportFailure();
		end
		if (got.Pwrite !== expReq.Pwrite)
		begin
			$display("FAIL Pwrite got %h expected %h", got.Pwrite, expReq.Pwrite);
			reportFailure();
		end
		if (expReq.Pwrite && got.Pwdata !== expReq.Pwdata)
		begin
			$display("FAIL Pwdata got %h expected %h", got.Pwdata, expReq.Pwdata);
			reportFailure();
		end
		if (got.Penable !== expReq.Penable)
		begin
			$display("FAIL Penable got %h expected %h", got.Penable, expReq.Penable);
			reportFailure();
		end
	endtask

	task automatic checkRdata(input logic [`AHB_APB_DATA_W-1:0] got,
		input logic [`AHB_APB_DATA_W-1:0] expData);
		if (got !== expData)
		begin
			$display("FAIL Hrdata got %h expected %h", got, expData);
			reportFailure();
		end
	endtask

	task automatic checkSel(input logic [`AHB_APB_NSLV-1:0] got,
		input logic [`AHB_APB_NSLV-1:0] expSel);
		if (got !== expSel)
		begin
			$display("FAIL Pselx got %h expected %h", got, expSel);
			reportFailure();
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic expBit);
		if (got !== expBit)
		begin
			$display("FAIL %s got %h expected %h", name, got, expBit);
			reportFailure();
		end
	endtask

	// Bursts of 1 to 4 beats, with IDLE and BUSY in between.
	task automatic pickTransfer(output ahbApbPkg::ahbReqS req, output logic [31:0] data);
		int kind;
		req.Hwrite = (randBelow(2) == 1);
		data       = $random(seed);
		kind       = (burstLeft == 0) ? randBelow(10) : 9;
		if (kind < 2)
		begin
			req.Htrans = (kind == 0) ? ahbApbPkg::IDLE : ahbApbPkg::BUSY;
			req.Haddr  = makeAddr(1'b0, randBelow(`AHB_APB_NSLV), randBelow(memWords));
		end
		else
		begin
			if (burstLeft == 0)
			begin
				burstLeft    = 1 + randBelow(4);
				burstOutside = (randBelow(8) == 0);
				burstRegion  = randBelow(`AHB_APB_NSLV);
				burstWord    = randBelow(memWords);
				req.Htrans   = ahbApbPkg::NONSEQ;
			end
			else
			begin
				burstWord  = (burstWord + 1) % memWords;
				req.Htrans = ahbApbPkg::SEQ;
			end
			burstLeft--;
			req.Haddr = makeAddr(burstOutside, burstRegion, burstWord);
		end
	endtask

	// Model of the accepted address phase.
	task automatic recordTransfer(input ahbApbPkg::ahbReqS req, input logic [31:0] data,
		output bit isRead, output logic [31:0] expData);
		ahbApbPkg::apbReqS expReq;
		int                region;
		isRead  = 1'b0;
		expData = '0;
		if ((req.Htrans == ahbApbPkg::NONSEQ || req.Htrans == ahbApbPkg::SEQ) &&
			req.Haddr >= `AHB_APB_BASE &&
			req.Haddr < `AHB_APB_BASE + `AHB_APB_NSLV * `AHB_APB_REGION)
		begin
			region                = int'((req.Haddr - `AHB_APB_BASE) / `AHB_APB_REGION);
			expReq.Paddr          = req.Haddr;
			expReq.Pwdata         = data;
			expReq.Pwrite         = req.Hwrite;
			expReq.Pselx          = '0;
			expReq.Pselx[region]  = 1'b1;
			expReq.Penable        = 1'b0;
			refQ.push_back(expReq);
			if (req.Hwrite)
				refMem[region][req.Haddr[5:2]] = data;
			isRead  = !req.Hwrite;
			expData = refMem[region][req.Haddr[5:2]];
		end
	endtask

	task automatic checkSetupCycle(output ahbApbPkg::apbReqS expReq);
		if (refQ.size() == 0)
		begin
			$display("APB setup cycle seen with no AHB transfer waiting for it");
			reportFailure();
		end
		expReq = refQ.pop_front();
		checkSel(apbReq.Pselx, expReq.Pselx);
		checkApb(apbReq, expReq);
	endtask

	task automatic checkAfterReset();
		@(posedge Hclk);
		for (int i = 0; i < 5; i++)
		begin
			checkSel(apbReq.Pselx, '0);
			checkBit("Penable", apbReq.Penable, 1'b0);
			checkBit("Pwrite", apbReq.Pwrite, 1'b0);
			checkBit("Hreadyout", Hreadyout, i != 0); // Rises one cycle after reset.
			@(posedge Hclk);
		end
	endtask

	task automatic runMaster();
		ahbApbPkg::ahbReqS          cur;
		logic [`AHB_APB_DATA_W-1:0] curData;
		bit                         pendRead;
		logic [`AHB_APB_DATA_W-1:0] pendExp;
		int                         issued;
		pendRead = 1'b0;
		pendExp  = '0;
		issued   = 0;
		pickTransfer(cur, curData);
		ahbReq <= cur;
		while (issued < numTransfers || pendRead)
		begin
			@(posedge Hclk);
			if (Hreadyout)
			begin
				if (pendRead)
					checkRdata(Hrdata, pendExp); // Read data phase ends here.
				pendRead = 1'b0;
				if (issued < numTransfers)
				begin
					recordTransfer(cur, curData, pendRead, pendExp);
					Hwdata <= curData;
					issued++;
				end
				if (issued < numTransfers)
					pickTransfer(cur, curData);
				else
					cur = idleReq;
				ahbReq <= cur;
			end
		end
	endtask

	// APB peripherals, zero wait states.
	always @(posedge Hclk)
	begin
		if (enablePending)
		begin
			checkSel(apbReq.Pselx, enableExp.Pselx); // Enable cycle right after setup.
			checkApb(apbReq, enableExp);
		end
		enablePending = 1'b0;
		if (Hresetn && apbReq.Pselx != '0)
		begin
			if (!apbReq.Penable)
			begin
				checkSetupCycle(enableExp);
				enableExp.Penable = 1'b1;
				enablePending     = 1'b1;
				if (!apbReq.Pwrite)
					Prdata <= periphMem[selIndex(apbReq.Pselx)][apbReq.Paddr[5:2]];
			end
			else if (apbReq.Pwrite)
			begin
				periphMem[selIndex(apbReq.Pselx)][apbReq.Paddr[5:2]] <= apbReq.Pwdata;
			end
		end
	end

	always @(posedge Hclk)
	begin
		if (dut.protocolChecks.failCount != 0)
		begin
			$display("A bus protocol assertion failed");
			reportFailure();
		end
	end

	initial
	begin
		#(watchdogCycles * clkPeriod);
		$display("Run timed out after %0d cycles", watchdogCycles);
		reportFailure();
	end

	initial
	begin
		for (int r = 0; r < `AHB_APB_NSLV; r++)
			for (int w = 0; w < memWords; w++)
			begin
				refMem[r][w]    = makeAddr(1'b0, r, w); // Unwritten words read as their address.
				periphMem[r][w] = makeAddr(1'b0, r, w);
			end
		Hresetn = 1'b0;
		ahbReq  = idleReq;
		Hwdata  = '0;
		Prdata  = '0;
		repeat (resetCycles) @(posedge Hclk);
		Hresetn <= 1'b1;
		checkAfterReset();
		runMaster();
		for (int i = 0; i < 16 && refQ.size() != 0; i++)
			@(posedge Hclk);
		repeat (4) @(posedge Hclk);
		if (refQ.size() != 0)
		begin
			$display("%0d expected APB transfers never appeared", refQ.size());
			reportFailure();
		end
		else
		begin
			$display("No errors");
			$finish;
		end
	end

endmodule

//--- files.f
+incdir+src
src/ahbApbPkg.sv
src/ahbSlaveInterface.sv
src/apbFsmController.sv
src/ahbApbBridge.sv
verification/ahbApbBridge_asserts.sv
verification/ahbApbBridgeTb.sv
